// File: src.f
+incdir+include
hdl/fill_pkg.sv
hdl/cmd_decode.sv
hdl/fill_walker.sv
hdl/frame_store.sv
hdl/fill_engine_top.sv
dv/fill_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fill engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fill_engine_tb \
    -f src.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/Vfill_engine_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// File: include/fill_tb_tasks.svh
/* Testbench LFSR, framebuffer reference model and typed compare tasks */
`ifndef FILL_TB_TASKS_SVH
`define FILL_TB_TASKS_SVH

localparam int TB_BPP   = 3;
localparam int TB_DEPTH = fill_pkg::NUM_ROWS * fill_pkg::NUM_COLS * TB_BPP;

logic [7:0] ref_mem [TB_DEPTH];
int         error_count = 0;
int         check_total = 0;

// ********************
// Stimulus and model
// ********************
// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic int ref_index(input int row, input int col, input int bsel);
    return (row * fill_pkg::NUM_COLS + col) * TB_BPP + bsel;
endfunction

// Every byte of every pixel in the inclusive box gets its colour byte
task automatic ref_fill(input int x1, input int y1, input int x2m1, input int y2m1,
                        input logic [31:0] color);
    for (int r = y1; r <= y2m1; r++) begin
        for (int c = x1; c <= x2m1; c++) begin
            for (int b = 0; b < TB_BPP; b++) begin
                ref_mem[ref_index(r, c, b)] = color[8*b +: 8];
            end
        end
    end
endtask

// ********************
// Compare tasks
// ********************
task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    check_total++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch %s: got %02h expected %02h at %0t", what, got, exp, $time);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    check_total++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch %s: got %b expected %b at %0t", what, got, exp, $time);
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    check_total++;
    if (got != exp) begin
        error_count++;
        $display("Mismatch %s: got %0d expected %0d at %0t", what, got, exp, $time);
    end
endtask

`endif

// File: dv/fill_engine_tb.sv
/* Fill engine testbench with clock, reset, stimulus table with LFSR rows, apply loop,
   full framebuffer readback, timeout and final report */
module fill_engine_tb;
    timeunit 1ns;
    timeprecision 100ps;

    `include "fill_tb_tasks.svh"

    localparam int NUM_TESTS = 15;

    typedef struct packed {
        fill_pkg::fill_cmd_t cmd;
        logic                exp_err;   // Decoder must reject it
        logic                second;    // Fire another fill mid-walk
    } tb_row_t;

    logic                clk;
    logic                reset;
    logic                cmd_valid;
    fill_pkg::fill_cmd_t cmd;
    fill_pkg::fb_addr_t  rd_addr;
    logic                busy;
    logic                done;
    logic                cmd_error;
    logic [7:0]          rd_data;

    tb_row_t     rows [NUM_TESTS];
    logic [15:0] lfsr_state = 16'd16276;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    fill_engine_top #(
        .BYTES_PER_PIXEL (TB_BPP)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rd_addr   (rd_addr),
        .busy      (busy),
        .done      (done),
        .cmd_error (cmd_error),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic tb_row_t make_row(input fill_pkg::fill_op_e op, input int x, input int y,
                                         input int w, input int h, input logic [31:0] color,
                                         input logic exp_err, input logic second);
        tb_row_t r;
        r.cmd.op     = op;
        r.cmd.x1     = fill_pkg::COL_BITS'(x);
        r.cmd.y1     = fill_pkg::ROW_BITS'(y);
        r.cmd.width  = (fill_pkg::COL_BITS + 1)'(w);
        r.cmd.height = (fill_pkg::ROW_BITS + 1)'(h);
        r.cmd.color  = color;
        r.exp_err    = exp_err;
        r.second     = second;
        return r;
    endfunction

    // Byte writes a row should cause
    function automatic int job_bytes(input tb_row_t r);
        if (r.exp_err) return 0;
        case (r.cmd.op)
            fill_pkg::OP_SET_PIXEL: return TB_BPP;
            fill_pkg::OP_FILL_AREA: return int'(r.cmd.width) * int'(r.cmd.height) * TB_BPP;
            fill_pkg::OP_CLEAR:     return TB_DEPTH;
            default:                return 0;
        endcase
    endfunction

    // ********************
    // Stimulus table
    // ********************
    task automatic build_table();
        int x;
        int y;
        rows[0]  = make_row(fill_pkg::OP_CLEAR,     0,  0,  0, 0, 32'h00102030, 1'b0, 1'b0);
        rows[1]  = make_row(fill_pkg::OP_NOP,       9,  9,  4, 4, 32'h00EEEEEE, 1'b0, 1'b0);
        rows[2]  = make_row(fill_pkg::OP_FILL_AREA, 5,  3, 10, 4, 32'h00332211, 1'b0, 1'b0);
        rows[3]  = make_row(fill_pkg::OP_SET_PIXEL, 63, 31, 1, 1, 32'h00CCBBAA, 1'b0, 1'b0);
        rows[4]  = make_row(fill_pkg::OP_SET_PIXEL, 0,  0,  0, 0, 32'h00564312, 1'b0, 1'b0);
        rows[5]  = make_row(fill_pkg::OP_FILL_AREA, 2,  2,  0, 5, 32'h00FFFFFF, 1'b1, 1'b0);
        rows[6]  = make_row(fill_pkg::OP_FILL_AREA, 2,  2,  5, 0, 32'h00FFFFFF, 1'b1, 1'b0);
        rows[7]  = make_row(fill_pkg::OP_FILL_AREA, 60, 1,  5, 2, 32'h00FFFFFF, 1'b1, 1'b0);
        rows[8]  = make_row(fill_pkg::OP_FILL_AREA, 1,  30, 2, 3, 32'h00FFFFFF, 1'b1, 1'b0);
        rows[9]  = make_row(fill_pkg::OP_FILL_AREA, 0,  0, 20, 8, 32'h00FEDCBA, 1'b0, 1'b1);
        rows[10] = make_row(fill_pkg::OP_FILL_AREA, 0,  0, 64, 32, 32'h00778899, 1'b0, 1'b0);
        for (int i = 11; i < NUM_TESTS; i++) begin
            x = int'(rand_bits(6));
            y = int'(rand_bits(5));
            rows[i] = make_row(fill_pkg::OP_FILL_AREA, x, y,
                               1 + int'(rand_bits(6)) % (fill_pkg::NUM_COLS - x),
                               1 + int'(rand_bits(5)) % (fill_pkg::NUM_ROWS - y),
                               rand_bits(24), 1'b0, 1'b0);
        end
        cycle_limit = 10;                       // Reset and margin
        for (int i = 0; i < NUM_TESTS; i++) begin
            cycle_limit += job_bytes(rows[i]) + 10 + 2 * TB_DEPTH;
        end
    endtask

    // Read every byte back at one address per cycle
    task automatic readback();
        int  prev;
        logic pending;
        pending = 1'b0;
        prev    = 0;
        for (int r = 0; r < fill_pkg::NUM_ROWS; r++) begin
            for (int c = 0; c < fill_pkg::NUM_COLS; c++) begin
                for (int b = 0; b < TB_BPP; b++) begin
                    @(negedge clk);
                    if (pending) check_byte($sformatf("rd_data byte %0d", prev), rd_data,
                                            ref_mem[prev]);
                    rd_addr.row  = fill_pkg::ROW_BITS'(r);
                    rd_addr.col  = fill_pkg::COL_BITS'(c);
                    rd_addr.bsel = fill_pkg::BYTE_SEL_BITS'(b);
                    prev         = ref_index(r, c, b);
                    pending      = 1'b1;
                end
            end
        end
        @(negedge clk);
        check_byte($sformatf("rd_data byte %0d", prev), rd_data, ref_mem[prev]);
    endtask

    // ********************
    // Apply one row
    // ********************
    task automatic run_row(input tb_row_t r);
        int      k;
        int      edges;
        int      busy_cycles;
        int      inject_edge;
        logic    done_seen;
        tb_row_t extra;
        k           = job_bytes(r);
        edges       = 0;
        busy_cycles = 0;
        inject_edge = -1;
        done_seen   = 1'b0;
        @(negedge clk);
        cmd       = r.cmd;
        cmd_valid = 1'b1;
        while (!done_seen && edges < k + 4) begin
            @(negedge clk);
            edges++;
            cmd_valid = 1'b0;
            done_seen = done;
            if (busy) busy_cycles++;
            check_flag("cmd_error", cmd_error,
                       (edges == 1) ? r.exp_err : (edges == inject_edge + 1));
            if (r.second && inject_edge < 0 && busy) begin
                extra       = make_row(fill_pkg::OP_FILL_AREA, 40, 20, 8, 4, 32'h00A5A5A5,
                                       1'b1, 1'b0);
                cmd         = extra.cmd;        // Must be dropped
                cmd_valid   = 1'b1;
                inject_edge = edges;
            end
        end
        check_flag("done", done_seen, k > 0);
        check_count("busy cycles", busy_cycles, k);
        if (k > 0) begin
            check_count("done edge", edges, k + 2);
            @(negedge clk);
            check_flag("done", done, 1'b0);     // Single pulse
            check_flag("busy", busy, 1'b0);
        end
        if (k > 0 && r.cmd.op == fill_pkg::OP_CLEAR) begin
            ref_fill(0, 0, fill_pkg::NUM_COLS - 1, fill_pkg::NUM_ROWS - 1, r.cmd.color);
        end else if (k > 0) begin
            ref_fill(int'(r.cmd.x1), int'(r.cmd.y1),
                     int'(r.cmd.x1) + ((r.cmd.op == fill_pkg::OP_FILL_AREA) ?
                                       int'(r.cmd.width) - 1 : 0),
                     int'(r.cmd.y1) + ((r.cmd.op == fill_pkg::OP_FILL_AREA) ?
                                       int'(r.cmd.height) - 1 : 0),
                     r.cmd.color);
        end
        readback();
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: no finish after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rd_addr   = '0;
        build_table();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_flag("busy", busy, 1'b0);         // All strobes quiet out of reset
        check_flag("done", done, 1'b0);
        check_flag("cmd_error", cmd_error, 1'b0);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(rows[i]);
        end
        $display("Checks: %0d, errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/fill_engine_top.sv
/* Rectangle fill engine top: command decode, fill walker and framebuffer */
module fill_engine_top #(
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  fill_pkg::fill_cmd_t cmd,
    input  fill_pkg::fb_addr_t  rd_addr,
    output logic                busy,
    output logic                done,
    output logic                cmd_error,
    output logic [7:0]          rd_data
);

    logic                job_valid;
    fill_pkg::fill_job_t job;
    logic                wr_en;
    fill_pkg::fb_write_t wr;

    cmd_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .job_valid (job_valid),
        .job       (job),
        .cmd_error (cmd_error)
    );

    fill_walker #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_walker (
        .clk       (clk),
        .reset     (reset),
        .job_valid (job_valid),
        .job       (job),
        .busy      (busy),
        .wr_en     (wr_en),
        .wr        (wr),
        .done      (done)
    );

    frame_store #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_store (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: hdl/frame_store.sv
/* Framebuffer byte memory with a single write port and a registered read port */
module frame_store #(
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                clk,
    input  logic                wr_en,
    input  fill_pkg::fb_write_t wr,
    input  fill_pkg::fb_addr_t  rd_addr,
    output logic [7:0]          rd_data
);

    localparam int DEPTH    = fill_pkg::NUM_ROWS * fill_pkg::NUM_COLS * BYTES_PER_PIXEL;
    localparam int IDX_BITS = $clog2(DEPTH);

    logic [7:0] mem [DEPTH];

    // Row-major, bytes of a pixel adjacent
    function automatic logic [IDX_BITS-1:0] byte_index(input fill_pkg::fb_addr_t a);
        int idx;
        idx = (int'(a.row) * fill_pkg::NUM_COLS + int'(a.col)) * BYTES_PER_PIXEL
            + int'(a.bsel);
        return IDX_BITS'(idx);
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en && (int'(wr.addr.bsel) < BYTES_PER_PIXEL)) begin
            mem[byte_index(wr.addr)] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (int'(rd_addr.bsel) < BYTES_PER_PIXEL) begin
            rd_data <= mem[byte_index(rd_addr)];
        end else begin
            rd_data <= 8'h00;            // Unused byte lane
        end
    end

endmodule

// File: hdl/fill_walker.sv
/* Fill walker FSM: steps a job's rectangle bottom-right to top-left,
   one framebuffer byte write per cycle, then pulses done */
module fill_walker #(
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                job_valid,
    input  fill_pkg::fill_job_t job,
    output logic                busy,
    output logic                wr_en,
    output fill_pkg::fb_write_t wr,
    output logic                done
);

    localparam logic [fill_pkg::BYTE_SEL_BITS-1:0] LAST_BYTE =
        fill_pkg::BYTE_SEL_BITS'(BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WALK,
        ST_FINISH
    } walk_state_e;

    walk_state_e         state;
    fill_pkg::fill_job_t cur_job;     // Latched copy of the job
    fill_pkg::fb_addr_t  next_addr;
    logic                last_step;

    function automatic logic [7:0] color_byte(
        input logic [31:0]                         color,
        input logic [fill_pkg::BYTE_SEL_BITS-1:0]  bsel
    );
        return color[8*bsel +: 8];
    endfunction

    // ********************
    // Walk order
    // ********************
    always_comb begin
        next_addr = wr.addr;
        last_step = (wr.addr.row == cur_job.y1) && (wr.addr.col == cur_job.x1)
                 && (wr.addr.bsel == '0);
        if (wr.addr.bsel != '0) begin
            next_addr.bsel = wr.addr.bsel - 1'b1;
        end else begin
            next_addr.bsel = LAST_BYTE;
            if (wr.addr.col == cur_job.x1) begin
                next_addr.col = cur_job.x2m1;       // Wrap to right edge
                next_addr.row = wr.addr.row - 1'b1;
            end else begin
                next_addr.col = wr.addr.col - 1'b1;
            end
        end
    end

    // ********************
    // Control
    // ********************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            busy  <= 1'b0;
            wr_en <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_valid) begin
                        state <= ST_WALK;
                        busy  <= 1'b1;
                        wr_en <= 1'b1;      // First byte goes out now
                    end
                end
                ST_WALK: begin
                    if (last_step) begin
                        state <= ST_FINISH;
                        busy  <= 1'b0;
                        wr_en <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                ST_FINISH: state <= ST_IDLE;  // done high this cycle
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Address and data of the write in progress
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && job_valid) begin
            cur_job      <= job;
            wr.addr.row  <= job.y2m1;
            wr.addr.col  <= job.x2m1;
            wr.addr.bsel <= LAST_BYTE;
            wr.data      <= color_byte(job.color, LAST_BYTE);
        end else if (state == ST_WALK && !last_step) begin
            wr.addr <= next_addr;
            wr.data <= color_byte(cur_job.color, next_addr.bsel);
        end
    end

endmodule

// File: hdl/cmd_decode.sv
/* Command decoder that range checks each command and issues a fill job or an error strobe */
module cmd_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  fill_pkg::fill_cmd_t cmd,
    input  logic                busy,
    output logic                job_valid,
    output fill_pkg::fill_job_t job,
    output logic                cmd_error
);

    // Two spare bits so corner plus size cannot wrap
    localparam int XW = fill_pkg::COL_BITS + 2;
    localparam int YW = fill_pkg::ROW_BITS + 2;

    logic [XW-1:0]       x_end;     // One past the last column
    logic [YW-1:0]       y_end;
    logic                fill_ok;
    logic                blocked;
    logic                accept;
    logic                reject;
    fill_pkg::fill_job_t next_job;

    assign x_end = XW'(cmd.x1) + XW'(cmd.width);
    assign y_end = YW'(cmd.y1) + YW'(cmd.height);

    assign fill_ok = (cmd.width != '0) && (cmd.height != '0)
                  && (x_end <= XW'(fill_pkg::NUM_COLS))
                  && (y_end <= YW'(fill_pkg::NUM_ROWS));

    // Walker running or our own job still in flight
    assign blocked = busy || job_valid;

    always_comb begin
        next_job.x1    = cmd.x1;
        next_job.y1    = cmd.y1;
        next_job.x2m1  = cmd.x1;        // 1x1 unless widened below
        next_job.y2m1  = cmd.y1;
        next_job.color = cmd.color;
        accept         = 1'b0;
        reject         = 1'b0;
        case (cmd.op)
            fill_pkg::OP_SET_PIXEL: begin
                accept = 1'b1;          // Corner fields only span the screen
            end
            fill_pkg::OP_FILL_AREA: begin
                next_job.x2m1 = fill_pkg::COL_BITS'(x_end - 1'b1);
                next_job.y2m1 = fill_pkg::ROW_BITS'(y_end - 1'b1);
                accept        = fill_ok;
                reject        = !fill_ok;
            end
            fill_pkg::OP_CLEAR: begin
                next_job.x1   = '0;
                next_job.y1   = '0;
                next_job.x2m1 = fill_pkg::COL_BITS'(fill_pkg::NUM_COLS - 1);
                next_job.y2m1 = fill_pkg::ROW_BITS'(fill_pkg::NUM_ROWS - 1);
                accept        = 1'b1;
            end
            default: ;                  // NOP does nothing
        endcase
        if (blocked && (accept || reject)) begin
            accept = 1'b0;              // No back-pressure so drop it
            reject = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            job_valid <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            job_valid <= cmd_valid && accept;
            cmd_error <= cmd_valid && reject;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && accept) begin
            job <= next_job;
        end
    end

endmodule

// File: hdl/fill_pkg.sv
/* Framebuffer geometry, fill opcode enum, and the command, job and
   framebuffer write structs shared by the fill engine */
package fill_pkg;

    // ********************
    // Screen geometry
    // ********************
    localparam int COL_BITS      = 6;
    localparam int ROW_BITS      = 5;
    localparam int NUM_COLS      = 64;
    localparam int NUM_ROWS      = 32;
    localparam int BYTE_SEL_BITS = 2;   // Up to 4 bytes per pixel

    // ********************
    // Opcodes
    // ********************
    typedef enum logic [1:0] {
        OP_NOP       = 2'd0,
        OP_SET_PIXEL = 2'd1,
        OP_FILL_AREA = 2'd2,
        OP_CLEAR     = 2'd3
    } fill_op_e;

    // ********************
    // Command and job
    // ********************
    typedef struct packed {
        fill_op_e              op;
        logic [COL_BITS-1:0]   x1;      // Top-left corner
        logic [ROW_BITS-1:0]   y1;
        logic [COL_BITS:0]     width;   // Extra bit so a full row fits
        logic [ROW_BITS:0]     height;
        logic [31:0]           color;   // Byte 0 in the low bits
    } fill_cmd_t;

    // Bounds are inclusive on both ends
    typedef struct packed {
        logic [COL_BITS-1:0]   x1;
        logic [ROW_BITS-1:0]   y1;
        logic [COL_BITS-1:0]   x2m1;
        logic [ROW_BITS-1:0]   y2m1;
        logic [31:0]           color;
    } fill_job_t;

    // ********************
    // Framebuffer access
    // ********************
    typedef struct packed {
        logic [ROW_BITS-1:0]      row;
        logic [COL_BITS-1:0]      col;
        logic [BYTE_SEL_BITS-1:0] bsel;  // Byte within the pixel
    } fb_addr_t;

    typedef struct packed {
        fb_addr_t    addr;
        logic [7:0]  data;
    } fb_write_t;

endpackage
